// ==== all.f ====
+incdir+include
logic/marlann_pkg.sv
logic/marlann_ifs.sv
logic/marlann_buffer.sv
logic/marlann_memory.sv
logic/marlann_xfer.sv
logic/marlann_cmd.sv
logic/marlann_top.sv
tests/marlann_sva.sv
tests/marlann_tb.sv

// ==== Bender.yml ====
package:
  name: marlann_host

export_include_dirs:
  - include

sources:
  - files:
      - logic/marlann_pkg.sv
      - logic/marlann_ifs.sv
      - logic/marlann_buffer.sv
      - logic/marlann_memory.sv
      - logic/marlann_xfer.sv
      - logic/marlann_cmd.sv
      - logic/marlann_top.sv
  - target: test
    files:
      - tests/marlann_sva.sv
      - tests/marlann_tb.sv

// ==== tests/marlann_tb.sv ====
/*
 * Marlann host engine testbench.
 * Runs a command table against a buffer and memory scoreboard.
 */
`timescale 1ns/1ps
`include "marlann_settings.svh"

module marlann_tb;

	typedef struct {
		logic [7:0]  code;
		logic [15:0] addr;
		logic [7:0]  len;
		int          count;
		logic [7:0]  result;
	} entry_t;

	logic               clock;
	logic               qpi_csb_di;
	logic               i_din_valid;
	logic               i_din_start;
	logic [`BYTE_W-1:0] i_din_data;
	logic               o_dout_valid;
	logic               i_dout_ready;
	logic [`BYTE_W-1:0] o_dout_data;

	logic [31:0]        seed = 32'h2c7b_d4b2;
	logic [`BYTE_W-1:0] buf_model [2*`BUF_WORDS];
	logic [`WORD_W-1:0] mem_model [`MEM_WORDS];
	entry_t             stim [$];
	int                 limit;

	marlann_top marlann_top_inst (
		.clock        (clock),
		.qpi_csb_di   (qpi_csb_di),
		.i_din_valid  (i_din_valid),
		.i_din_start  (i_din_start),
		.i_din_data   (i_din_data),
		.o_dout_valid (o_dout_valid),
		.i_dout_ready (i_dout_ready),
		.o_dout_data  (o_dout_data)
	);

	bind marlann_cmd marlann_sva sva_inst (
		.clock        (clock),
		.qpi_csb_di   (qpi_csb_di),
		.i_din_cmd    (cmd_valid),
		.i_dout_valid (o_dout_valid),
		.i_dout_ready (i_dout_ready),
		.i_dout_data  (o_dout_data),
		.i_start      (cfg.start),
		.i_busy       (cfg.busy),
		.i_mem_req    (marlann_tb.marlann_top_inst.mem_bus.req)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// ========================================
	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Length byte in units of four, zero is the full buffer.
	function automatic int bytes_for_len(input logic [7:0] len);
		return (len == 8'h00) ? 1024 : 4 * int'(len);
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] want,
			input string what);
		if (got !== want) begin
			$display("ERR at %0t ns: %s, got %0h, expected %0h", $time, what, got, want);
			$display(">>> FAIL");
			$fatal(1, "Value mismatch.");
		end
	endtask

	task automatic send_byte(input logic start, input logic [7:0] data);
		@(posedge clock);
		i_din_valid <= 1'b1;
		i_din_start <= start;
		i_din_data  <= data;
	endtask

	task automatic idle_input();
		@(posedge clock);
		i_din_valid <= 1'b0;
		i_din_start <= 1'b0;
	endtask

	// Start byte drops pending output, status raises it again.
	task automatic send_command(input logic [7:0] code);
		send_byte(1'b1, code);
		idle_input();
		@(negedge clock);
		if (code != marlann_pkg::CMD_STATUS)
			check_value(o_dout_valid, 0, "output valid after start byte");
	endtask

	task automatic take_byte(input bit gaps, output logic [7:0] b);
		bit          taken;
		logic [31:0] r;
		taken = 1'b0;
		while (!taken) begin
			@(posedge clock);
			r = lcg_next();
			i_dout_ready <= !gaps || (r[9:8] != 2'b00);
			@(negedge clock);
			if (o_dout_valid && i_dout_ready) begin
				b = o_dout_data;
				taken = 1'b1;
			end
		end
	endtask

	task automatic release_ready();
		@(posedge clock);
		i_dout_ready <= 1'b0;
	endtask

	// FFh while the transfer runs, then the final byte.
	task automatic await_response(input logic [7:0] final_byte);
		logic [7:0] b;
		take_byte(1'b0, b);
		check_value(b, 8'hFF, "first transfer response");
		while (b != final_byte) begin
			take_byte(1'b0, b);
			if (b != final_byte)
				check_value(b, 8'hFF, "transfer response while busy");
		end
		release_ready();
	endtask

	task automatic add_entry(input logic [7:0] code, input logic [15:0] addr,
			input logic [7:0] len, input int count, input logic [7:0] result);
		stim.push_back('{code, addr, len, count, result});
	endtask

	// ========================================
	task automatic apply_entry(input entry_t e);
		logic [7:0]  b;
		logic [31:0] r;
		int          idx;
		send_command(e.code);
		case (e.code)
			marlann_pkg::CMD_STATUS: begin
				take_byte(1'b0, b);
				release_ready();
				check_value(b, e.result, "status byte");
			end
			marlann_pkg::CMD_WBUF: begin
				for (int i = 0; i < e.count; i++) begin
					r = lcg_next();
					buf_model[i] = r[23:16];
					send_byte(1'b0, r[23:16]);
				end
				idle_input();
			end
			marlann_pkg::CMD_RBUF: begin
				for (int i = 0; i < e.count; i++) begin
					take_byte(1'b1, b);
					check_value(b, buf_model[i], $sformatf("read buffer byte %0d", i));
				end
				release_ready();
				@(negedge clock);
				check_value(o_dout_valid, 1, "next buffer byte pending");
			end
			marlann_pkg::CMD_WMEM, marlann_pkg::CMD_RMEM: begin
				send_byte(1'b0, e.addr[7:0]);
				send_byte(1'b0, e.addr[15:8]);
				send_byte(1'b0, e.len);
				idle_input();
				await_response(e.result);
				// Low byte first, addresses wrap on the memory depth.
				for (int i = 0; i < e.count / 2; i++) begin
					idx = (e.addr + i) % `MEM_WORDS;
					if (e.code == marlann_pkg::CMD_WMEM)
						mem_model[idx] = {buf_model[2*i+1], buf_model[2*i]};
					else
						{buf_model[2*i+1], buf_model[2*i]} = mem_model[idx];
				end
			end
			default: ;
		endcase
	endtask

	initial begin
		int          total;
		logic [31:0] r;
		logic [15:0] addr_a;
		logic [15:0] addr_b;
		qpi_csb_di   = 1'b1;
		i_din_valid  = 1'b0;
		i_din_start  = 1'b0;
		i_din_data   = '0;
		i_dout_ready = 1'b0;

		r = lcg_next();
		addr_a = r[31:16];
		r = lcg_next();
		// Second window runs past the end of memory.
		addr_b = {r[31:26], 10'h300};

		add_entry(marlann_pkg::CMD_STATUS, 16'h0, 8'h00, 1, 8'h00);
		add_entry(marlann_pkg::CMD_WBUF, 16'h0, 8'h00, 1024, 8'h00);
		add_entry(marlann_pkg::CMD_RBUF, 16'h0, 8'h00, 1024, 8'h00);
		add_entry(marlann_pkg::CMD_WMEM, addr_a, 8'h10, bytes_for_len(8'h10), 8'h00);
		add_entry(marlann_pkg::CMD_STATUS, 16'h0, 8'h00, 1, 8'h00);
		add_entry(marlann_pkg::CMD_WBUF, 16'h0, 8'h00, 1024, 8'h00);
		add_entry(marlann_pkg::CMD_RMEM, addr_a, 8'h10, bytes_for_len(8'h10), 8'h00);
		add_entry(marlann_pkg::CMD_RBUF, 16'h0, 8'h00, 1024, 8'h00);
		add_entry(marlann_pkg::CMD_WMEM, addr_b, 8'h00, bytes_for_len(8'h00), 8'h00);
		add_entry(marlann_pkg::CMD_WBUF, 16'h0, 8'h00, 1024, 8'h00);
		add_entry(marlann_pkg::CMD_RMEM, addr_b, 8'h00, bytes_for_len(8'h00), 8'h00);
		add_entry(marlann_pkg::CMD_RBUF, 16'h0, 8'h00, 1024, 8'h00);
		// Partial read, cut off by the next start byte.
		add_entry(marlann_pkg::CMD_RBUF, 16'h0, 8'h00, 300, 8'h00);
		add_entry(marlann_pkg::CMD_WBUF, 16'h0, 8'h00, 16, 8'h00);
		add_entry(marlann_pkg::CMD_RBUF, 16'h0, 8'h00, 16, 8'h00);
		add_entry(marlann_pkg::CMD_STATUS, 16'h0, 8'h00, 1, 8'h00);

		total = 0;
		foreach (stim[i])
			total += stim[i].count + 64;
		limit = total * 12 + 20;
		fork
			begin
				repeat (limit) @(posedge clock);
				$display("Timeout: the run did not finish within %0d clock cycles.", limit);
				$display(">>> FAIL");
				$fatal(1, "Watchdog expired.");
			end
		join_none

		repeat (10) @(posedge clock);
		qpi_csb_di <= 1'b0;
		@(negedge clock);
		check_value(o_dout_valid, 0, "output valid after reset");

		foreach (stim[i])
			apply_entry(stim[i]);

		@(posedge clock);
		if (marlann_top_inst.cmd_inst.sva_inst.fail_count == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			$display("Protocol assertions failed %0d times.",
				marlann_top_inst.cmd_inst.sva_inst.fail_count);
			$display(">>> FAIL");
			$fatal(1, "Assertion failures.");
		end
	end

endmodule

// ==== tests/marlann_sva.sv ====
/*
 * Command decoder protocol assertions.
 * Output hold, transfer start and memory request rules.
 */
`timescale 1ns/1ps
`include "marlann_settings.svh"

module marlann_sva (
	input logic               clock,
	input logic               qpi_csb_di,
	input logic               i_din_cmd,
	input logic               i_dout_valid,
	input logic               i_dout_ready,
	input logic [`BYTE_W-1:0] i_dout_data,
	input logic               i_start,
	input logic               i_busy,
	input logic               i_mem_req
);

	int fail_count = 0;

	// Held byte stays put until taken or a command arrives.
	hold_output: assert property (@(posedge clock) disable iff (qpi_csb_di)
		i_dout_valid && !i_dout_ready && !i_din_cmd
			|=> i_dout_valid && $stable(i_dout_data))
	else begin
		fail_count++;
		$error("Output byte changed while held.");
	end

	busy_needs_start: assert property (@(posedge clock) disable iff (qpi_csb_di)
		$rose(i_busy) |-> $past(i_start))
	else begin
		fail_count++;
		$error("Busy rose without a start pulse.");
	end

	// Memory traffic only inside a transfer.
	req_inside_busy: assert property (@(posedge clock) disable iff (qpi_csb_di)
		i_mem_req |-> i_busy)
	else begin
		fail_count++;
		$error("Memory request while not busy.");
	end

endmodule

// ==== logic/marlann_top.sv ====
/*
 * Marlann host command engine, top level.
 * Byte stream in and out, staging buffer and main memory behind it.
 */
`timescale 1ns/1ps
`include "marlann_settings.svh"

module marlann_top (
	input  logic               clock,
	input  logic               qpi_csb_di,

	input  logic               i_din_valid,
	input  logic               i_din_start,
	input  logic [`BYTE_W-1:0] i_din_data,

	output logic               o_dout_valid,
	input  logic               i_dout_ready,
	output logic [`BYTE_W-1:0] o_dout_data
);

	buf_port_if #(.ADDR_W(`BUF_PTR_W - 1), .DATA_W(`BYTE_W)) byte_bus ();
	buf_port_if #(.ADDR_W(`BUF_PTR_W - 2), .DATA_W(`WORD_W)) word_bus ();
	mem_port_if mem_bus ();
	xfer_cfg_if cfg_bus ();

	marlann_cmd cmd_inst (
		.clock        (clock),
		.qpi_csb_di   (qpi_csb_di),
		.i_din_valid  (i_din_valid),
		.i_din_start  (i_din_start),
		.i_din_data   (i_din_data),
		.o_dout_valid (o_dout_valid),
		.i_dout_ready (i_dout_ready),
		.o_dout_data  (o_dout_data),
		.bp           (byte_bus.master),
		.cfg          (cfg_bus.control)
	);

	marlann_xfer xfer_inst (
		.clock      (clock),
		.qpi_csb_di (qpi_csb_di),
		.cfg        (cfg_bus.engine),
		.bp         (word_bus.master),
		.mp         (mem_bus.master)
	);

	marlann_buffer buffer_inst (
		.clock     (clock),
		.byte_port (byte_bus.slave),
		.word_port (word_bus.slave)
	);

	marlann_memory memory_inst (
		.clock      (clock),
		.qpi_csb_di (qpi_csb_di),
		.mp         (mem_bus.slave)
	);

endmodule

// ==== logic/marlann_cmd.sv ====
/*
 * Marlann command decoder.
 * Parses the host byte stream, moves bytes to and from the staging
 * buffer, holds the transfer registers and answers status.
 */
`timescale 1ns/1ps
`include "marlann_settings.svh"

module marlann_cmd (
	input  logic               clock,
	input  logic               qpi_csb_di,

	input  logic               i_din_valid,
	input  logic               i_din_start,
	input  logic [`BYTE_W-1:0] i_din_data,

	output logic               o_dout_valid,
	input  logic               i_dout_ready,
	output logic [`BYTE_W-1:0] o_dout_data,

	buf_port_if.master         bp,
	xfer_cfg_if.control        cfg
);

	marlann_pkg::cmd_state_e state;
	marlann_pkg::buf_ptr_t   ptr;
	marlann_pkg::buf_ptr_t   scaled_len;
	marlann_pkg::mem_addr_t  addr_q;
	marlann_pkg::buf_ptr_t   len_q;
	marlann_pkg::xfer_dir_e  dir_q;
	logic                    start_q;
	logic                    dout_valid;
	logic [`BYTE_W-1:0]      dout_q;
	logic [`BYTE_W-1:0]      status_byte;
	logic                    cmd_valid;
	logic                    arg_valid;
	logic                    out_free;
	logic                    wr_en;
	logic                    rd_en;
	logic                    run_state;

	assign cmd_valid = i_din_valid && i_din_start;
	assign arg_valid = i_din_valid && !i_din_start;
	assign out_free  = !dout_valid || i_dout_ready;
	assign run_state = (state == marlann_pkg::ST_WMEM_RUN) || (state == marlann_pkg::ST_RMEM_RUN);

	// Zero means a full buffer.
	assign scaled_len = (i_din_data == '0) ? marlann_pkg::buf_ptr_t'(2 * `BUF_WORDS) :
		marlann_pkg::buf_ptr_t'(i_din_data) << `LEN_SCALE_BITS;

	// Start counts as busy until the engine answers.
	assign status_byte = {`BYTE_W{cfg.busy || start_q}};

	// ========================================
	// Buffer byte port.
	assign wr_en = arg_valid && (state == marlann_pkg::ST_WBUF);
	assign rd_en = !cmd_valid && out_free && (state == marlann_pkg::ST_RBUF);

	assign bp.en    = wr_en || rd_en;
	assign bp.we    = wr_en;
	assign bp.addr  = ptr[`BUF_PTR_W-2:0];
	assign bp.wdata = i_din_data;

	assign cfg.start = start_q;
	assign cfg.dir   = dir_q;
	assign cfg.addr  = addr_q;
	assign cfg.len   = len_q;

	// Read buffer streams straight from the buffer port.
	assign o_dout_valid = dout_valid;
	assign o_dout_data  = (state == marlann_pkg::ST_RBUF) ? bp.rdata : dout_q;

	// ========================================
	always_ff @(posedge clock or posedge qpi_csb_di) begin
		if (qpi_csb_di) begin
			state      <= marlann_pkg::ST_HALT;
			ptr        <= '0;
			dout_valid <= 1'b0;
			start_q    <= 1'b0;
			addr_q     <= '0;
			len_q      <= '0;
			dir_q      <= marlann_pkg::TO_MEM;
		end else begin
			start_q <= 1'b0;
			if (cmd_valid) begin
				dout_valid <= 1'b0;
				ptr        <= '0;
				case (marlann_pkg::cmd_e'(i_din_data))
					marlann_pkg::CMD_STATUS: begin
						dout_valid <= 1'b1;
						state      <= marlann_pkg::ST_STATUS;
					end
					marlann_pkg::CMD_WBUF: state <= marlann_pkg::ST_WBUF;
					marlann_pkg::CMD_RBUF: state <= marlann_pkg::ST_RBUF;
					marlann_pkg::CMD_WMEM: state <= marlann_pkg::ST_WMEM_A0;
					marlann_pkg::CMD_RMEM: state <= marlann_pkg::ST_RMEM_A0;
					default: state <= marlann_pkg::ST_HALT;
				endcase
			end else begin
				if (arg_valid) begin
					case (state)
						marlann_pkg::ST_WBUF: ptr <= ptr + 1'b1;
						marlann_pkg::ST_WMEM_A0, marlann_pkg::ST_RMEM_A0: begin
							addr_q[`BYTE_W-1:0] <= i_din_data;
							state <= (state == marlann_pkg::ST_WMEM_A0) ?
								marlann_pkg::ST_WMEM_A1 : marlann_pkg::ST_RMEM_A1;
						end
						marlann_pkg::ST_WMEM_A1, marlann_pkg::ST_RMEM_A1: begin
							addr_q[`MEM_ADDR_W-1:`BYTE_W] <= i_din_data;
							state <= (state == marlann_pkg::ST_WMEM_A1) ?
								marlann_pkg::ST_WMEM_LEN : marlann_pkg::ST_RMEM_LEN;
						end
						marlann_pkg::ST_WMEM_LEN, marlann_pkg::ST_RMEM_LEN: begin
							len_q      <= scaled_len;
							start_q    <= 1'b1;
							dout_valid <= 1'b1;
							if (state == marlann_pkg::ST_WMEM_LEN) begin
								dir_q <= marlann_pkg::TO_MEM;
								state <= marlann_pkg::ST_WMEM_RUN;
							end else begin
								dir_q <= marlann_pkg::FROM_MEM;
								state <= marlann_pkg::ST_RMEM_RUN;
							end
						end
						default: ;
					endcase
				end
				if (rd_en)
					ptr <= ptr + 1'b1;
				if (state == marlann_pkg::ST_RBUF)
					dout_valid <= rd_en || (dout_valid && !i_dout_ready);
			end
		end
	end

	// Response byte, held while the host is not ready.
	always_ff @(posedge clock) begin
		if (cmd_valid)
			dout_q <= status_byte;
		else if (arg_valid && (state == marlann_pkg::ST_WMEM_LEN ||
				state == marlann_pkg::ST_RMEM_LEN))
			dout_q <= '1;
		else if (out_free && (state == marlann_pkg::ST_STATUS || run_state))
			dout_q <= status_byte;
	end

endmodule

// ==== logic/marlann_xfer.sv ====
/*
 * Marlann transfer engine.
 * Copies words between the staging buffer and main memory.
 */
`timescale 1ns/1ps
`include "marlann_settings.svh"

module marlann_xfer (
	input  logic        clock,
	input  logic        qpi_csb_di,
	xfer_cfg_if.engine  cfg,
	buf_port_if.master  bp,
	mem_port_if.master  mp
);

	marlann_pkg::buf_ptr_t   ptr;
	marlann_pkg::buf_ptr_t   len;
	marlann_pkg::buf_ptr_t   rd_ptr;
	marlann_pkg::mem_addr_t  maddr;
	marlann_pkg::xfer_dir_e  dir;
	logic                    wr_pend;
	logic                    rd_wait;
	logic                    rd_drop;
	logic                    in_flight;
	logic                    to_mem;
	logic                    buf_rd;
	logic                    mem_rd;
	logic                    fill;

	assign to_mem = (dir == marlann_pkg::TO_MEM);

	// Buffer read runs one word ahead of the memory write.
	assign rd_ptr = wr_pend ? ptr + 2'd2 : ptr;
	assign buf_rd = to_mem && (rd_ptr != len);
	assign mem_rd = !to_mem && !rd_wait && (ptr != len);
	assign fill   = mp.done && !rd_drop;

	// A read still out when a new transfer starts is thrown away.
	assign in_flight = (rd_wait && !mp.done) || mem_rd;

	assign bp.en    = buf_rd || fill;
	assign bp.we    = fill;
	assign bp.addr  = fill ? ptr[`BUF_PTR_W-2:1] : rd_ptr[`BUF_PTR_W-2:1];
	assign bp.wdata = mp.rdata;

	assign mp.req   = wr_pend || mem_rd;
	assign mp.we    = wr_pend;
	assign mp.addr  = maddr;
	assign mp.wdata = bp.rdata;

	assign cfg.busy = (ptr != len);

	always_ff @(posedge clock or posedge qpi_csb_di) begin
		if (qpi_csb_di) begin
			ptr     <= '0;
			len     <= '0;
			maddr   <= '0;
			dir     <= marlann_pkg::TO_MEM;
			wr_pend <= 1'b0;
			rd_wait <= 1'b0;
			rd_drop <= 1'b0;
		end else if (cfg.start) begin
			ptr     <= '0;
			len     <= cfg.len;
			maddr   <= cfg.addr;
			dir     <= cfg.dir;
			wr_pend <= 1'b0;
			rd_wait <= in_flight;
			rd_drop <= in_flight;
		end else begin
			wr_pend <= buf_rd;
			if (wr_pend || fill) begin
				ptr   <= ptr + 2'd2;
				maddr <= maddr + 1'b1;
			end
			if (mem_rd)
				rd_wait <= 1'b1;
			if (mp.done) begin
				rd_wait <= 1'b0;
				rd_drop <= 1'b0;
			end
		end
	end

endmodule

// ==== logic/marlann_memory.sv ====
/*
 * Marlann main memory model.
 * Single port word memory with a fixed read latency.
 */
`timescale 1ns/1ps
`include "marlann_settings.svh"

module marlann_memory (
	input  logic      clock,
	input  logic      qpi_csb_di,
	mem_port_if.slave mp
);

	logic [`WORD_W-1:0]            mem [`MEM_WORDS];
	logic [`WORD_W-1:0]            rd_pipe [`MEM_LATENCY];
	logic [`MEM_LATENCY-1:0]       vld_pipe;
	logic [$clog2(`MEM_WORDS)-1:0] idx;

	// Addresses wrap on the implemented depth.
	assign idx = mp.addr[$clog2(`MEM_WORDS)-1:0];

	always_ff @(posedge clock) begin
		if (mp.req && mp.we)
			mem[idx] <= mp.wdata;
		rd_pipe[0] <= mem[idx];
		for (int i = 1; i < `MEM_LATENCY; i++)
			rd_pipe[i] <= rd_pipe[i-1];
	end

	always_ff @(posedge clock or posedge qpi_csb_di) begin
		if (qpi_csb_di)
			vld_pipe <= '0;
		else
			vld_pipe <= {vld_pipe[`MEM_LATENCY-2:0], mp.req && !mp.we};
	end

	assign mp.done  = vld_pipe[`MEM_LATENCY-1];
	assign mp.rdata = rd_pipe[`MEM_LATENCY-1];

endmodule

// ==== logic/marlann_buffer.sv ====
/*
 * Marlann staging buffer.
 * Byte port for the host side, word port for the transfer engine.
 */
`timescale 1ns/1ps
`include "marlann_settings.svh"

module marlann_buffer (
	input  logic       clock,
	buf_port_if.slave  byte_port,
	buf_port_if.slave  word_port
);

	logic [`WORD_W-1:0]   mem [`BUF_WORDS];
	logic [`BUF_PTR_W-3:0] byte_word;
	logic                  byte_half;

	// Low address bit picks the half, low byte first.
	assign byte_word = byte_port.addr[`BUF_PTR_W-2:1];
	assign byte_half = byte_port.addr[0];

	always_ff @(posedge clock) begin
		if (word_port.en && word_port.we)
			mem[word_port.addr] <= word_port.wdata;
		if (byte_port.en && byte_port.we)
			mem[byte_word][byte_half*`BYTE_W +: `BYTE_W] <= byte_port.wdata;

		if (word_port.en && !word_port.we)
			word_port.rdata <= mem[word_port.addr];
		if (byte_port.en && !byte_port.we)
			byte_port.rdata <= mem[byte_word][byte_half*`BYTE_W +: `BYTE_W];
	end

endmodule

// ==== logic/marlann_ifs.sv ====
/*
 * Marlann internal buses.
 * Staging buffer port, main memory port and transfer configuration.
 */
`timescale 1ns/1ps
`include "marlann_settings.svh"

// ========================================
// Buffer port, read data one cycle after en.
interface buf_port_if #(
	parameter int ADDR_W = `BUF_PTR_W - 1,
	parameter int DATA_W = `BYTE_W
);
	logic              en;
	logic              we;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic [DATA_W-1:0] rdata;

	modport master (output en, we, addr, wdata, input rdata);
	modport slave  (input en, we, addr, wdata, output rdata);
endinterface

// ========================================
// Memory port, one request outstanding.
interface mem_port_if;
	logic                  req;
	logic                  we;
	marlann_pkg::mem_addr_t addr;
	logic [`WORD_W-1:0]    wdata;
	logic [`WORD_W-1:0]    rdata;
	logic                  done;

	modport master (output req, we, addr, wdata, input rdata, done);
	modport slave  (input req, we, addr, wdata, output rdata, done);
endinterface

// ========================================
// Transfer setup from the decoder.
interface xfer_cfg_if;
	logic                   start;
	marlann_pkg::xfer_dir_e dir;
	marlann_pkg::mem_addr_t addr;
	marlann_pkg::buf_ptr_t  len;
	logic                   busy;

	modport control (output start, dir, addr, len, input busy);
	modport engine  (input start, dir, addr, len, output busy);
endinterface

// ==== logic/marlann_pkg.sv ====
/*
 * Marlann shared types.
 * Command codes, decoder states, transfer direction and pointer types.
 */
`include "marlann_settings.svh"

package marlann_pkg;

	typedef enum logic [`BYTE_W-1:0] {
		CMD_STATUS = 8'h20,
		CMD_WBUF   = 8'h21,
		CMD_RBUF   = 8'h22,
		CMD_WMEM   = 8'h23,
		CMD_RMEM   = 8'h24
	} cmd_e;

	typedef enum logic [3:0] {
		ST_HALT, ST_STATUS, ST_WBUF, ST_RBUF,
		ST_WMEM_A0, ST_WMEM_A1, ST_WMEM_LEN, ST_WMEM_RUN,
		ST_RMEM_A0, ST_RMEM_A1, ST_RMEM_LEN, ST_RMEM_RUN
	} cmd_state_e;

	typedef enum logic {
		TO_MEM   = 1'b0,
		FROM_MEM = 1'b1
	} xfer_dir_e;

	typedef logic [`BUF_PTR_W-1:0] buf_ptr_t;
	typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

endpackage

// ==== include/marlann_settings.svh ====
/*
 * Marlann host engine sizes.
 * Stream, buffer and memory widths, depths and timing.
 */
`ifndef MARLANN_SETTINGS_SVH
`define MARLANN_SETTINGS_SVH

// Host byte stream.
`define BYTE_W 8

// Staging buffer, word organized, byte addressed.
`define WORD_W 16
`define BUF_WORDS 512
`define BUF_PTR_W 11

// Main memory.
`define MEM_ADDR_W 16
`define MEM_WORDS 1024
`define MEM_LATENCY 2

// Length byte counts units of four bytes.
`define LEN_SCALE_BITS 2

`endif
